// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := cpu_tb
FILELIST  := build.f

SOURCES := $(filter-out +incdir%,$(shell cat $(FILELIST))) dv/cpu_ref_model.svh
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf obj_dir

// File: build.f
+incdir+dv
common/cpu_isa_pkg.sv
common/cpu_pipe_pkg.sv
source/control.sv
source/alu.sv
source/register_file.sv
source/forwarding_unit.sv
cpu/cpu.sv
dv/cpu_tb.sv

// File: common/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

	localparam int word_width = 16;
	localparam int reg_count = 4;

	typedef logic [word_width-1:0] word_t;
	typedef logic [$clog2(reg_count)-1:0] reg_addr_t;

	// JAL and JRL always link into this register
	localparam reg_addr_t link_reg = 2'd2;

	// Instruction bits 15..12
	typedef enum logic [3:0] {
		op_bne   = 4'd0,
		op_beq   = 4'd1,
		op_bgz   = 4'd2,
		op_blz   = 4'd3,
		op_adi   = 4'd4,
		op_ori   = 4'd5,
		op_lhi   = 4'd6,
		op_lwd   = 4'd7,
		op_swd   = 4'd8,
		op_jmp   = 4'd9,
		op_jal   = 4'd10,
		op_alu_r = 4'd15
	} opcode_e;

	// R-type function field, bits 5..0
	typedef enum logic [5:0] {
		fn_add = 6'd0,
		fn_sub = 6'd1,
		fn_and = 6'd2,
		fn_orr = 6'd3,
		fn_not = 6'd4,
		fn_tcp = 6'd5,
		fn_shl = 6'd6,
		fn_shr = 6'd7,
		fn_jpr = 6'd25,
		fn_jrl = 6'd26,
		fn_wwd = 6'd28,
		fn_hlt = 6'd29
	} funct_e;

	// Same order as funct codes 0..7
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_not,
		alu_tcp,
		alu_shl,
		alu_shr
	} alu_op_e;

endpackage

`default_nettype wire

// File: common/cpu_pipe_pkg.sv
`default_nettype none

package cpu_pipe_pkg;

	import cpu_isa_pkg::*;

	// ORI takes a zero-extended immediate, the rest sign-extend
	typedef enum logic [1:0] {
		src_reg,
		src_imm,
		src_imm_zero,
		src_lhi
	} alu_src_e;

	typedef enum logic [1:0] {
		dest_rd,
		dest_rt,
		dest_link
	} reg_dest_e;

	typedef enum logic [1:0] {
		fwd_reg,
		fwd_mem,
		fwd_wb
	} fwd_sel_e;

	typedef struct packed {
		logic valid;
		alu_op_e alu_op;
		alu_src_e alu_src;
		reg_dest_e reg_dest;
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic mem_to_reg;
		logic pc_to_reg;
		logic branch;
		logic jtype;
		logic rtype_jump;
		logic is_wwd;
		logic is_halt;
	} ctrl_t;

	typedef struct packed {
		word_t pc_plus_one;
		word_t instruction;
		logic valid;
	} if_id_t;

	typedef struct packed {
		ctrl_t ctrl;
		opcode_e opcode;
		word_t pc_plus_one;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t dest;
		word_t rs_value;
		word_t rt_value;
		word_t immediate;
		word_t jump_target;
	} id_ex_t;

	typedef struct packed {
		ctrl_t ctrl;
		reg_addr_t dest;
		word_t alu_result;
		word_t store_value;
		word_t pc_plus_one;
		word_t a_value;
	} ex_mem_t;

	typedef struct packed {
		ctrl_t ctrl;
		reg_addr_t dest;
		word_t alu_result;
		word_t load_value;
		word_t pc_plus_one;
		word_t a_value;
	} mem_wb_t;

endpackage

`default_nettype wire

// File: cpu/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;
(
	input logic Clk,
	input logic rst,
	output logic i_read,
	output word_t i_address,
	input word_t i_data,
	output logic d_read,
	output logic d_write,
	output word_t d_address,
	output word_t d_wdata,
	input word_t d_rdata,
	output word_t output_port,
	output logic output_valid,
	output word_t num_inst,
	output logic is_halted
);

	word_t pc;
	logic halt_fetch;
	if_id_t if_id;
	id_ex_t id_ex;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;

	ctrl_t dec_ctrl;
	ctrl_t id_ctrl;
	word_t rf_data1;
	word_t rf_data2;
	word_t id_imm;
	reg_addr_t id_dest;
	logic load_use;
	logic fetch_stop;

	fwd_sel_e fwd_a;
	fwd_sel_e fwd_b;
	word_t mem_fwd_value;
	word_t wb_value;
	word_t a_value;
	word_t b_value;
	word_t alu_a;
	word_t alu_b;
	word_t alu_result;
	logic cond;
	logic redirect;
	word_t redirect_target;

	// Decode
	control u_control (
		.instruction(if_id.instruction),
		.ctrl(dec_ctrl)
	);

	register_file u_register_file (
		.Clk(Clk),
		.rst(rst),
		.read_addr1(if_id.instruction[11:10]),
		.read_addr2(if_id.instruction[9:8]),
		.write_addr(mem_wb.dest),
		.write_data(wb_value),
		.write_en(mem_wb.ctrl.reg_write),
		.read_data1(rf_data1),
		.read_data2(rf_data2)
	);

	assign id_ctrl = if_id.valid ? dec_ctrl : '0;
	assign id_imm = {{8{if_id.instruction[7]}}, if_id.instruction[7:0]};

	always_comb begin
		case (id_ctrl.reg_dest)
			dest_rt:   id_dest = if_id.instruction[9:8];
			dest_link: id_dest = link_reg;
			default:   id_dest = if_id.instruction[7:6];
		endcase
	end

	// Stalls on a match with either source field
	assign load_use = id_ex.ctrl.mem_read && if_id.valid &&
		(id_ex.dest == if_id.instruction[11:10] || id_ex.dest == if_id.instruction[9:8]);
	assign fetch_stop = halt_fetch || id_ex.ctrl.is_halt || id_ctrl.is_halt;

	assign i_read = !fetch_stop;
	assign i_address = pc;

	// Execute
	forwarding_unit u_forwarding_unit (
		.ex_rs(id_ex.rs),
		.ex_rt(id_ex.rt),
		.mem_dest(ex_mem.dest),
		.mem_reg_write(ex_mem.ctrl.reg_write),
		.wb_dest(mem_wb.dest),
		.wb_reg_write(mem_wb.ctrl.reg_write),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b)
	);

	assign mem_fwd_value = ex_mem.ctrl.pc_to_reg ? ex_mem.pc_plus_one : ex_mem.alu_result;
	assign wb_value = mem_wb.ctrl.mem_to_reg ? mem_wb.load_value :
		mem_wb.ctrl.pc_to_reg ? mem_wb.pc_plus_one : mem_wb.alu_result;

	assign a_value = (fwd_a == fwd_mem) ? mem_fwd_value :
		(fwd_a == fwd_wb) ? wb_value : id_ex.rs_value;
	assign b_value = (fwd_b == fwd_mem) ? mem_fwd_value :
		(fwd_b == fwd_wb) ? wb_value : id_ex.rt_value;

	assign alu_a = (id_ex.ctrl.alu_src == src_lhi) ? '0 : a_value;

	always_comb begin
		case (id_ex.ctrl.alu_src)
			src_imm:      alu_b = id_ex.immediate;
			src_imm_zero: alu_b = {8'h00, id_ex.immediate[7:0]};
			src_lhi:      alu_b = {id_ex.immediate[7:0], 8'h00};
			default:      alu_b = b_value;
		endcase
	end

	alu u_alu (
		.a(alu_a),
		.b(alu_b),
		.op(id_ex.ctrl.alu_op),
		.result(alu_result)
	);

	always_comb begin
		case (id_ex.opcode)
			op_bne:  cond = (a_value != b_value);
			op_beq:  cond = (a_value == b_value);
			op_bgz:  cond = !a_value[word_width-1] && (a_value != '0);
			op_blz:  cond = a_value[word_width-1];
			default: cond = 1'b0;
		endcase
	end

	// Static not-taken, so any taken branch or jump redirects
	assign redirect = (id_ex.ctrl.branch && cond) || id_ex.ctrl.jtype || id_ex.ctrl.rtype_jump;
	assign redirect_target = id_ex.ctrl.rtype_jump ? a_value :
		id_ex.ctrl.jtype ? id_ex.jump_target : id_ex.pc_plus_one + id_ex.immediate;

	// Memory
	assign d_read = ex_mem.ctrl.mem_read;
	assign d_write = ex_mem.ctrl.mem_write;
	assign d_address = ex_mem.alu_result;
	assign d_wdata = ex_mem.store_value;

	always_ff @(posedge Clk) begin
		if (rst) begin
			pc <= '0;
			halt_fetch <= 1'b0;
			if_id <= '0;
			id_ex <= '0;
			ex_mem <= '0;
			mem_wb <= '0;
			output_port <= '0;
			output_valid <= 1'b0;
			num_inst <= '0;
			is_halted <= 1'b0;
		end else begin
			if (redirect)
				pc <= redirect_target;
			else if (!load_use && !fetch_stop)
				pc <= pc + 1'b1;

			if (redirect || (fetch_stop && !load_use))
				if_id <= '0;
			else if (!load_use)
				if_id <= '{pc_plus_one: pc + 1'b1, instruction: i_data, valid: 1'b1};

			if (redirect || load_use)
				id_ex <= '0;
			else
				id_ex <= '{ctrl: id_ctrl, opcode: opcode_e'(if_id.instruction[15:12]),
					pc_plus_one: if_id.pc_plus_one, rs: if_id.instruction[11:10],
					rt: if_id.instruction[9:8], dest: id_dest, rs_value: rf_data1,
					rt_value: rf_data2, immediate: id_imm,
					jump_target: {if_id.pc_plus_one[15:12], if_id.instruction[11:0]}};

			ex_mem <= '{ctrl: id_ex.ctrl, dest: id_ex.dest, alu_result: alu_result,
				store_value: b_value, pc_plus_one: id_ex.pc_plus_one, a_value: a_value};
			mem_wb <= '{ctrl: ex_mem.ctrl, dest: ex_mem.dest, alu_result: ex_mem.alu_result,
				load_value: d_rdata, pc_plus_one: ex_mem.pc_plus_one, a_value: ex_mem.a_value};

			// HLT in execute is past every older redirect
			halt_fetch <= halt_fetch || id_ex.ctrl.is_halt;

			// Retire
			output_valid <= mem_wb.ctrl.is_wwd;
			if (mem_wb.ctrl.is_wwd)
				output_port <= mem_wb.a_value;
			if (mem_wb.ctrl.valid)
				num_inst <= num_inst + 1'b1;
			if (mem_wb.ctrl.is_halt)
				is_halted <= 1'b1;
		end
	end

	a_mem_exclusive: assert property (@(posedge Clk) disable iff (rst) !(d_read && d_write));
	// Every latch clears on reset, so a WWD needs five edges to reach the port
	a_no_output_in_reset: assert property (@(posedge Clk) disable iff (rst)
		output_valid |-> !($past(rst, 1) || $past(rst, 2) || $past(rst, 3) ||
			$past(rst, 4) || $past(rst, 5)));
	a_halt_freezes_count: assert property (@(posedge Clk) disable iff (rst)
		is_halted |=> $stable(num_inst));

endmodule

`default_nettype wire

// File: dv/cpu_ref_model.svh
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// Runs prog_mem one instruction at a time on a private copy of the state.
// Fills expected_q with the WWD words and returns the retire count, HLT included.
function automatic int run_model();
	word_t regs [4];
	word_t mem [256];
	word_t pc;
	word_t ins;
	word_t a;
	word_t b;
	word_t imm;
	word_t nxt;
	word_t addr;
	int count;
	for (int i = 0; i < 4; i++)
		regs[i] = '0;
	for (int i = 0; i < 256; i++)
		mem[i] = data_init[i];
	expected_q.delete();
	pc = '0;
	count = 0;
	for (int step = 0; step < 4000; step++) begin
		ins = prog_mem[pc[7:0]];
		a = regs[ins[11:10]];
		b = regs[ins[9:8]];
		imm = {{8{ins[7]}}, ins[7:0]};
		addr = a + imm;
		nxt = pc + 16'd1;
		count++;
		case (opcode_e'(ins[15:12]))
			op_alu_r: begin
				case (funct_e'(ins[5:0]))
					fn_add: regs[ins[7:6]] = a + b;
					fn_sub: regs[ins[7:6]] = a - b;
					fn_and: regs[ins[7:6]] = a & b;
					fn_orr: regs[ins[7:6]] = a | b;
					fn_not: regs[ins[7:6]] = ~a;
					fn_tcp: regs[ins[7:6]] = 16'd0 - a;
					fn_shl: regs[ins[7:6]] = a << 1;
					fn_shr: regs[ins[7:6]] = {a[15], a[15:1]};
					fn_jpr: nxt = a;
					fn_jrl: begin
						regs[2] = pc + 16'd1;
						nxt = a;
					end
					fn_wwd: expected_q.push_back(a);
					fn_hlt: return count;
					default: ;
				endcase
			end
			op_adi: regs[ins[9:8]] = a + imm;
			op_ori: regs[ins[9:8]] = a | {8'h00, ins[7:0]};
			op_lhi: regs[ins[9:8]] = {ins[7:0], 8'h00};
			op_lwd: regs[ins[9:8]] = mem[addr[7:0]];
			op_swd: mem[addr[7:0]] = b;
			op_bne: if (a != b) nxt = pc + 16'd1 + imm;
			op_beq: if (a == b) nxt = pc + 16'd1 + imm;
			op_bgz: if (!a[15] && a != 16'd0) nxt = pc + 16'd1 + imm;
			op_blz: if (a[15]) nxt = pc + 16'd1 + imm;
			op_jmp: nxt = {nxt[15:12], ins[11:0]};
			op_jal: begin
				regs[2] = pc + 16'd1;
				nxt = {nxt[15:12], ins[11:0]};
			end
			default: ;
		endcase
		pc = nxt;
	end
	return -1;
endfunction

`endif

// File: dv/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb
	import cpu_isa_pkg::*;
;

	logic Clk;
	logic rst;
	logic i_read;
	word_t i_address;
	word_t i_data;
	logic d_read;
	logic d_write;
	word_t d_address;
	word_t d_wdata;
	word_t d_rdata;
	word_t output_port;
	logic output_valid;
	word_t num_inst;
	logic is_halted;

	word_t imem [256];
	word_t dmem [256];
	word_t prog_mem [256];
	word_t data_init [256];
	word_t expected_q [$];
	int prog_len;
	logic [31:0] rng_state = 32'h331a;

	string cur_name;
	int out_idx;
	int test_errors;
	int tests_failed;
	int tests_run;
	logic checking;
	logic running;
	int cycle_count;
	int cycle_limit;

	`include "cpu_ref_model.svh"

	cpu DUT (
		.Clk(Clk), .rst(rst), .i_read(i_read), .i_address(i_address), .i_data(i_data),
		.d_read(d_read), .d_write(d_write), .d_address(d_address), .d_wdata(d_wdata),
		.d_rdata(d_rdata), .output_port(output_port), .output_valid(output_valid),
		.num_inst(num_inst), .is_halted(is_halted)
	);

	// Memories answer only when strobed
	assign i_data = i_read ? imem[i_address[7:0]] : '0;
	assign d_rdata = d_read ? dmem[d_address[7:0]] : '0;

	always @(posedge Clk)
		if (d_write)
			dmem[d_address[7:0]] <= d_wdata;

	initial begin
		Clk = 1'b0;
		forever #4 Clk = ~Clk;
	end

	function automatic logic [31:0] xorshift();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic word_t r_word(funct_e fn, int rs, int rt, int rd);
		return {4'hf, rs[1:0], rt[1:0], rd[1:0], fn};
	endfunction

	function automatic word_t imm_word(opcode_e op, int rs, int rt, int imm);
		return {op, rs[1:0], rt[1:0], imm[7:0]};
	endfunction

	function automatic word_t jump_word(opcode_e op, int target);
		return {op, target[11:0]};
	endfunction

	task automatic emit(input word_t w);
		prog_mem[prog_len] = w;
		prog_len++;
	endtask

	task automatic clear_program();
		for (int i = 0; i < 256; i++) begin
			prog_mem[i] = r_word(fn_hlt, 0, 0, 0);
			data_init[i] = {i[7:0], ~i[7:0]} ^ 16'h3c5a;
		end
		prog_len = 0;
	endtask

	// Compare each output word in order against the model
	always @(negedge Clk) begin
		if (checking && output_valid) begin
			if (is_halted) begin
				$display("%s: output_valid pulsed after halt", cur_name);
				test_errors++;
			end else if (out_idx >= expected_q.size()) begin
				$display("%s: more outputs than the model produced", cur_name);
				test_errors++;
			end else if (output_port !== expected_q[out_idx]) begin
				$display("FAIL %s output %0d expected %h actual %h", cur_name, out_idx,
					expected_q[out_idx], output_port);
				test_errors++;
			end
			out_idx++;
		end
	end

	// Watchdog
	always @(posedge Clk) begin
		if (running) begin
			cycle_count++;
			if (cycle_count > cycle_limit) begin
				$display("%s timed out after %0d cycles without halting", cur_name, cycle_count);
				$display("Simulation FAILED");
				$finish;
			end
		end
	end

	task automatic run_test(input string name);
		int expected_count;
		word_t halt_count;
		expected_count = run_model();
		cur_name = name;
		out_idx = 0;
		test_errors = 0;
		@(posedge Clk);
		rst <= 1'b1;
		repeat (8) @(posedge Clk);
		for (int i = 0; i < 256; i++) begin
			imem[i] = prog_mem[i];
			dmem[i] = data_init[i];
		end
		cycle_limit = 20 * expected_count + 100;
		cycle_count = 0;
		checking = 1'b1;
		running = 1'b1;
		rst <= 1'b0;
		@(negedge Clk);
		while (!is_halted)
			@(negedge Clk);
		running = 1'b0;
		halt_count = num_inst;
		if (num_inst !== word_t'(expected_count)) begin
			$display("FAIL %s num_inst expected %0d actual %0d", name, expected_count, num_inst);
			test_errors++;
		end
		if (out_idx != expected_q.size()) begin
			$display("FAIL %s output count expected %0d actual %0d", name,
				expected_q.size(), out_idx);
			test_errors++;
		end
		repeat (20) @(negedge Clk);
		if (num_inst !== halt_count) begin
			$display("%s: num_inst changed after halt", name);
			test_errors++;
		end
		if (i_read !== 1'b0) begin
			$display("%s: instruction fetch still active after halt", name);
			test_errors++;
		end
		checking = 1'b0;
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("%s: %0d outputs, %0d retired, %0d errors", name, out_idx, halt_count,
			test_errors);
	endtask

	initial begin
		rst = 1'b1;
		checking = 1'b0;
		running = 1'b0;
		tests_run = 0;
		tests_failed = 0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;
			dmem[i] = '0;
		end

		// Dependent ALU chain
		clear_program();
		emit(imm_word(op_lhi, 0, 1, 8'h12));
		emit(imm_word(op_ori, 1, 1, 8'h34));
		emit(imm_word(op_adi, 0, 2, -3));
		emit(r_word(fn_add, 1, 2, 3));
		emit(r_word(fn_wwd, 3, 0, 0));
		for (int f = 1; f < 8; f++) begin
			emit(r_word(funct_e'(f), 3, 1, 3));
			emit(r_word(fn_wwd, 3, 0, 0));
		end
		emit(r_word(fn_sub, 1, 2, 0));
		emit(imm_word(op_adi, 1, 1, 1));
		emit(r_word(fn_wwd, 0, 0, 0));
		emit(r_word(fn_wwd, 1, 0, 0));
		emit(r_word(fn_hlt, 0, 0, 0));
		run_test("alu_chain");

		// Store, load and load-use
		clear_program();
		emit(imm_word(op_adi, 0, 1, 8'h10));
		emit(imm_word(op_adi, 0, 2, 8'h55));
		emit(imm_word(op_swd, 1, 2, 2));
		emit(imm_word(op_lwd, 1, 3, 2));
		emit(r_word(fn_add, 3, 3, 0));
		emit(r_word(fn_wwd, 0, 0, 0));
		emit(imm_word(op_lwd, 1, 3, 5));
		emit(r_word(fn_wwd, 3, 0, 0));
		emit(imm_word(op_swd, 1, 3, 0));
		emit(imm_word(op_lwd, 1, 0, 0));
		emit(r_word(fn_wwd, 0, 0, 0));
		emit(r_word(fn_hlt, 0, 0, 0));
		run_test("load_store");

		// Branches taken and not taken, plus a small loop
		clear_program();
		emit(imm_word(op_adi, 0, 1, 5));
		emit(imm_word(op_adi, 0, 2, 5));
		emit(imm_word(op_beq, 1, 2, 2));
		emit(r_word(fn_wwd, 1, 0, 0));
		emit(r_word(fn_wwd, 2, 0, 0));
		emit(imm_word(op_bne, 1, 2, 1));
		emit(r_word(fn_wwd, 1, 0, 0));
		emit(imm_word(op_bgz, 1, 0, 1));
		emit(r_word(fn_wwd, 2, 0, 0));
		emit(imm_word(op_blz, 1, 0, 1));
		emit(r_word(fn_wwd, 1, 0, 0));
		emit(imm_word(op_adi, 0, 3, -1));
		emit(imm_word(op_blz, 3, 0, 1));
		emit(r_word(fn_wwd, 3, 0, 0));
		emit(imm_word(op_bgz, 3, 0, 1));
		emit(r_word(fn_wwd, 3, 0, 0));
		emit(imm_word(op_adi, 0, 0, 1));
		emit(imm_word(op_bne, 0, 1, 1));
		emit(r_word(fn_wwd, 0, 0, 0));
		emit(imm_word(op_beq, 0, 1, 1));
		emit(r_word(fn_wwd, 0, 0, 0));
		emit(imm_word(op_adi, 0, 0, 2));
		emit(r_word(fn_wwd, 0, 0, 0));
		emit(imm_word(op_adi, 0, 0, -1));
		emit(imm_word(op_bgz, 0, 0, -3));
		emit(r_word(fn_hlt, 0, 0, 0));
		run_test("branches");

		// Jumps and links
		clear_program();
		emit(jump_word(op_jal, 3));
		emit(r_word(fn_wwd, 1, 0, 0));
		emit(r_word(fn_wwd, 1, 0, 0));
		emit(r_word(fn_wwd, 2, 0, 0));
		emit(imm_word(op_adi, 0, 1, 8));
		emit(r_word(fn_jpr, 1, 0, 0));
		emit(r_word(fn_wwd, 0, 0, 0));
		emit(r_word(fn_wwd, 0, 0, 0));
		emit(imm_word(op_adi, 0, 3, 12));
		emit(r_word(fn_jrl, 3, 0, 0));
		emit(r_word(fn_wwd, 2, 0, 0));
		emit(r_word(fn_hlt, 0, 0, 0));
		emit(r_word(fn_wwd, 2, 0, 0));
		emit(jump_word(op_jmp, 15));
		emit(r_word(fn_wwd, 0, 0, 0));
		emit(imm_word(op_adi, 0, 0, 1));
		emit(r_word(fn_wwd, 0, 0, 0));
		emit(r_word(fn_jpr, 2, 0, 0));
		run_test("jumps");

		// Random straight-line programs
		for (int t = 0; t < 4; t++) begin
			logic [31:0] r;
			clear_program();
			for (int k = 0; k < 4; k++)
				emit(imm_word(op_lhi, 0, k, xorshift()));
			for (int n = 0; n < 48; n++) begin
				r = xorshift();
				case (r[2:0])
					3'd0, 3'd1, 3'd2: emit(r_word(funct_e'(r[10:8]), r[4:3], r[6:5], r[12:11]));
					3'd3: emit(imm_word(op_adi, r[4:3], r[6:5], r[23:16]));
					3'd4: emit(imm_word(op_ori, r[4:3], r[6:5], r[23:16]));
					3'd5: emit(imm_word(r[7] ? op_lhi : op_swd, r[4:3], r[6:5], r[23:16]));
					3'd6: emit(imm_word(op_lwd, r[4:3], r[6:5], r[23:16]));
					default: emit(r_word(fn_wwd, r[4:3], 0, 0));
				endcase
			end
			for (int k = 0; k < 4; k++)
				emit(r_word(fn_wwd, k, 0, 0));
			emit(r_word(fn_hlt, 0, 0, 0));
			run_test($sformatf("random_%0d", t));
		end

		$display("%0d tests run, %0d failed", tests_run, tests_failed);
		if (tests_failed == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
	import cpu_isa_pkg::*;
(
	input word_t a,
	input word_t b,
	input alu_op_e op,
	output word_t result
);

	always_comb begin
		case (op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_not: result = ~a;
			alu_tcp: result = ~a + 1'b1;
			// Single-bit shifts, right shift keeps the sign
			alu_shl: result = {a[word_width-2:0], 1'b0};
			alu_shr: result = {a[word_width-1], a[word_width-1:1]};
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: source/control.sv
`timescale 1ns/1ps
`default_nettype none

module control
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;
(
	input word_t instruction,
	output ctrl_t ctrl
);

	opcode_e opcode;
	funct_e funct;

	assign opcode = opcode_e'(instruction[15:12]);
	assign funct = funct_e'(instruction[5:0]);

	always_comb begin
		ctrl = '0;
		case (opcode)
			op_alu_r: begin
				case (funct)
					fn_add, fn_sub, fn_and, fn_orr, fn_not, fn_tcp, fn_shl, fn_shr: begin
						ctrl.valid = 1'b1;
						ctrl.reg_write = 1'b1;
						ctrl.reg_dest = dest_rd;
						ctrl.alu_op = alu_op_e'(instruction[2:0]);
					end
					fn_wwd: begin
						ctrl.valid = 1'b1;
						ctrl.is_wwd = 1'b1;
					end
					fn_jpr, fn_jrl: begin
						ctrl.valid = 1'b1;
						ctrl.rtype_jump = 1'b1;
						ctrl.reg_write = (funct == fn_jrl);
						ctrl.pc_to_reg = (funct == fn_jrl);
						ctrl.reg_dest = dest_link;
					end
					fn_hlt: begin
						ctrl.valid = 1'b1;
						ctrl.is_halt = 1'b1;
					end
					default: ;
				endcase
			end
			op_adi, op_ori, op_lhi, op_lwd: begin
				ctrl.valid = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.reg_dest = dest_rt;
				ctrl.alu_op = (opcode == op_ori) ? alu_or : alu_add;
				ctrl.alu_src = (opcode == op_ori) ? src_imm_zero :
					(opcode == op_lhi) ? src_lhi : src_imm;
				ctrl.mem_read = (opcode == op_lwd);
				ctrl.mem_to_reg = (opcode == op_lwd);
			end
			op_swd: begin
				ctrl.valid = 1'b1;
				ctrl.mem_write = 1'b1;
				ctrl.alu_src = src_imm;
				ctrl.alu_op = alu_add;
			end
			op_bne, op_beq, op_bgz, op_blz: begin
				ctrl.valid = 1'b1;
				ctrl.branch = 1'b1;
			end
			op_jmp, op_jal: begin
				ctrl.valid = 1'b1;
				ctrl.jtype = 1'b1;
				ctrl.reg_write = (opcode == op_jal);
				ctrl.pc_to_reg = (opcode == op_jal);
				ctrl.reg_dest = dest_link;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: source/forwarding_unit.sv
`timescale 1ns/1ps
`default_nettype none

module forwarding_unit
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;
(
	input reg_addr_t ex_rs,
	input reg_addr_t ex_rt,
	input reg_addr_t mem_dest,
	input logic mem_reg_write,
	input reg_addr_t wb_dest,
	input logic wb_reg_write,
	output fwd_sel_e fwd_a,
	output fwd_sel_e fwd_b
);

	// Newest producer first
	function automatic fwd_sel_e pick(input reg_addr_t src);
		if (mem_reg_write && mem_dest == src)
			return fwd_mem;
		if (wb_reg_write && wb_dest == src)
			return fwd_wb;
		return fwd_reg;
	endfunction

	assign fwd_a = pick(ex_rs);
	assign fwd_b = pick(ex_rt);

endmodule

`default_nettype wire

// File: source/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file
	import cpu_isa_pkg::*;
(
	input logic Clk,
	input logic rst,
	input reg_addr_t read_addr1,
	input reg_addr_t read_addr2,
	input reg_addr_t write_addr,
	input word_t write_data,
	input logic write_en,
	output word_t read_data1,
	output word_t read_data2
);

	word_t regs [reg_count];

	always_ff @(posedge Clk) begin
		if (rst) begin
			regs <= '{default: '0};
		end else if (write_en) begin
			regs[write_addr] <= write_data;
		end
	end

	// Writeback in the same cycle shows up in decode
	assign read_data1 = (write_en && write_addr == read_addr1) ? write_data : regs[read_addr1];
	assign read_data2 = (write_en && write_addr == read_addr2) ? write_data : regs[read_addr2];

endmodule

`default_nettype wire
